//--- hw/usbRxPkg.sv
package usbRxPkg;

    // ======================================
    // Data widths
    // ======================================

    // One received byte, first bit on the wire ends up in bit 0
    typedef logic [7:0] UsbByte;

    // PID type field as found in the low nibble of the PID byte
    typedef logic [3:0] PidCode;

    // DATA0 type code
    // Its low two bits are shared by every data PID
    localparam PidCode pidData0 = 4'b0011;

    // Last four SYNC line states KJKK decode to 0,0,0,1
    // After shifting LSB first they sit in the upper nibble as 1000
    localparam logic [3:0] syncPattern = 4'b1000;

    // Full-speed bit time in clk48 cycles
    localparam int clksPerBit = 4;

    // ======================================
    // Packet framer FSM
    // ======================================
    typedef enum logic [1:0] {
        waitSync,
        getPid,
        waitEop,
        rearm
    } FramerState;

endpackage

//--- hw/usbLineSampler.sv
`timescale 1ns/10ps

module usbLineSampler #(
    parameter int resetSe0Clocks = 120,
    parameter int syncStages = 2
) (
    input  logic clk48,
    input  logic rstN,
    input  logic dataInP,
    input  logic dataInN,
    input  logic ackUsbReset,
    output logic bitStrobe,
    output logic lineBit,
    output logic lineValid,
    output logic eopSeen,
    output logic usbResetDetect
);

    localparam int phaseWidth = $clog2(usbRxPkg::clksPerBit);
    localparam int se0Width = $clog2(resetSe0Clocks + 1);
    localparam logic [se0Width-1:0] se0Limit = se0Width'(resetSe0Clocks);

    logic [syncStages-1:0] syncP;
    logic [syncStages-1:0] syncN;
    logic lineEdge;
    logic se0;
    logic jState;
    logic [phaseWidth-1:0] bitPhase;
    logic [se0Width-1:0] se0Count;

    // ======================================
    // Input synchronizer
    // ======================================

    // Reset to idle J so no SE0 is seen at startup
    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            syncP <= '1;
            syncN <= '0;
        end else begin
            syncP <= {syncP[syncStages-2:0], dataInP};
            syncN <= {syncN[syncStages-2:0], dataInN};
        end
    end

    assign lineBit = syncP[syncStages-1];
    assign lineValid = syncP[syncStages-1] ^ syncN[syncStages-1];
    assign se0 = ~syncP[syncStages-1] & ~syncN[syncStages-1];
    assign jState = syncP[syncStages-1] & ~syncN[syncStages-1];

    // Edge seen one stage early so the phase restarts with lineBit
    assign lineEdge = syncP[syncStages-1] ^ syncP[syncStages-2];

    // ======================================
    // Bit-phase recovery
    // ======================================

    // Free-running bit counter, realigned on every D+ transition
    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            bitPhase <= '0;
        end else if (lineEdge) begin
            bitPhase <= '0;
        end else if (bitPhase == phaseWidth'(usbRxPkg::clksPerBit - 1)) begin
            bitPhase <= '0;
        end else begin
            bitPhase <= bitPhase + 1'b1;
        end
    end

    // Strobe in the middle of the bit cell
    assign bitStrobe = (bitPhase == phaseWidth'(usbRxPkg::clksPerBit / 2 - 1));

    // ======================================
    // EOP and bus reset
    // ======================================
    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            se0Count <= '0;
            eopSeen <= 1'b0;
            usbResetDetect <= 1'b0;
        end else begin
            // SE0 in the previous clock and J now
            eopSeen <= (se0Count != '0) && jState;
            // Saturating SE0 length counter
            if (!se0) begin
                se0Count <= '0;
            end else if (se0Count != se0Limit) begin
                se0Count <= se0Count + 1'b1;
            end
            // Latched until the host side acknowledges
            if (ackUsbReset) begin
                usbResetDetect <= 1'b0;
            end else if (se0Count == se0Limit) begin
                usbResetDetect <= 1'b1;
            end
        end
    end

endmodule

//--- hw/usbBitDecoder.sv
`timescale 1ns/10ps

module usbBitDecoder (
    input  logic clk48,
    input  logic rstN,
    input  logic bitStrobe,
    input  logic lineBit,
    input  logic rearm,
    output logic decodedBit,
    output logic bitValid,
    output logic stuffError
);

    logic prevLine;
    logic nrziBit;
    logic [2:0] onesCount;

    // NRZI: no level change means a one
    assign nrziBit = (lineBit == prevLine);

    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            prevLine <= 1'b1;
            onesCount <= '0;
            decodedBit <= 1'b0;
            bitValid <= 1'b0;
            stuffError <= 1'b0;
        end else if (rearm) begin
            // Back to idle J between packets
            prevLine <= 1'b1;
            onesCount <= '0;
            bitValid <= 1'b0;
            stuffError <= 1'b0;
        end else if (bitStrobe) begin
            prevLine <= lineBit;
            if (onesCount == 3'd6) begin
                // Stuffed bit is dropped and must be a zero
                bitValid <= 1'b0;
                stuffError <= nrziBit;
                onesCount <= '0;
            end else begin
                decodedBit <= nrziBit;
                bitValid <= 1'b1;
                stuffError <= 1'b0;
                onesCount <= nrziBit ? onesCount + 1'b1 : 3'd0;
            end
        end else begin
            // Strobes last one clock only
            bitValid <= 1'b0;
            stuffError <= 1'b0;
        end
    end

endmodule

//--- hw/usbRxCrc.sv
`timescale 1ns/10ps

module usbRxCrc (
    input  logic clk48,
    input  logic rstN,
    input  logic crcClear,
    input  logic useCrc16,
    input  logic bitValid,
    input  logic decodedBit,
    output logic crcGood
);

    localparam logic [15:0] crc16Poly = 16'h8005;
    localparam logic [4:0] crc5Poly = 5'b00101;
    // Register contents after a correct packet including its CRC field
    localparam logic [15:0] crc16Residual = 16'h800D;
    localparam logic [4:0] crc5Residual = 5'b01100;

    logic [15:0] crcReg;
    logic [15:0] crcNext;
    logic sel16;
    logic fb16;
    logic fb5;

    assign fb16 = decodedBit ^ crcReg[15];
    assign fb5 = decodedBit ^ crcReg[4];

    // CRC5 runs in the low five bits only
    always_comb begin
        if (sel16) begin
            crcNext = {crcReg[14:0], 1'b0} ^ (fb16 ? crc16Poly : 16'h0000);
        end else begin
            crcNext = {crcReg[15:5], {crcReg[3:0], 1'b0} ^ (fb5 ? crc5Poly : 5'b00000)};
        end
    end

    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            crcReg <= '1;
            sel16 <= 1'b0;
        end else if (crcClear) begin
            // Preset and pick the polynomial from the PID
            crcReg <= '1;
            sel16 <= useCrc16;
        end else if (bitValid) begin
            crcReg <= crcNext;
        end
    end

    assign crcGood = sel16 ? (crcReg == crc16Residual) : (crcReg[4:0] == crc5Residual);

endmodule

//--- hw/usbRxFramer.sv
`timescale 1ns/10ps

module usbRxFramer (
    input  logic clk48,
    input  logic rstN,
    input  logic decodedBit,
    input  logic bitValid,
    input  logic stuffError,
    input  logic lineValid,
    input  logic eopSeen,
    input  logic crcGood,
    output logic crcClear,
    output logic useCrc16,
    output logic rearm,
    output logic byteStrobe,
    output logic byteIsData,
    output logic byteIsLast,
    output logic packetDropped,
    output usbRxPkg::UsbByte byteOut
);

    usbRxPkg::FramerState state;
    usbRxPkg::UsbByte shiftReg;
    usbRxPkg::PidCode pidReg;
    usbRxPkg::UsbByte pipe0;
    usbRxPkg::UsbByte pipe1;
    usbRxPkg::UsbByte pipe2;
    logic [2:0] bitCnt;
    logic [2:0] pipeValid;
    logic [2:0] dataTag;
    logic [2:0] lastTag;
    logic [1:0] flushCnt;
    logic byteFull;
    logic lastCrcGood;
    logic dropFlag;
    logic syncFound;
    logic pidOk;
    logic isDataPid;
    logic shiftPipe;
    logic flushing;

    assign syncFound = (state == usbRxPkg::waitSync) && (shiftReg[7:4] == usbRxPkg::syncPattern);
    assign pidOk = (shiftReg[7:4] == ~shiftReg[3:0]);
    assign isDataPid = (pidReg[1:0] == usbRxPkg::pidData0[1:0]);
    // PID is still in the shift register on the last clock of crcClear
    assign useCrc16 = (shiftReg[1:0] == usbRxPkg::pidData0[1:0]);
    assign crcClear = (state != usbRxPkg::waitEop);
    assign rearm = (state == usbRxPkg::rearm);
    assign flushing = (state == usbRxPkg::rearm);
    assign shiftPipe = byteFull && ((state == usbRxPkg::getPid)
                                 || (state == usbRxPkg::waitEop && !eopSeen));
    assign packetDropped = dropFlag;

    // ======================================
    // Deserializer, LSB first
    // ======================================
    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            shiftReg <= '1;
            bitCnt <= '0;
            byteFull <= 1'b0;
        end else if (state == usbRxPkg::rearm) begin
            // All ones cannot fake a SYNC tail
            shiftReg <= '1;
            bitCnt <= '0;
            byteFull <= 1'b0;
        end else begin
            byteFull <= bitValid && (bitCnt == 3'd7) && (state != usbRxPkg::waitSync);
            if (syncFound) begin
                bitCnt <= '0;
            end else if (bitValid) begin
                shiftReg <= {decodedBit, shiftReg[7:1]};
                bitCnt <= bitCnt + 1'b1;
            end
        end
    end

    // ======================================
    // Packet FSM
    // ======================================
    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            state <= usbRxPkg::waitSync;
            pidReg <= '0;
            dropFlag <= 1'b0;
            lastCrcGood <= 1'b1;
            flushCnt <= '0;
        end else begin
            case (state)
                usbRxPkg::waitSync: begin
                    if (syncFound) begin
                        state <= usbRxPkg::getPid;
                        dropFlag <= 1'b0;
                        // Packets without CRC field stay good
                        lastCrcGood <= 1'b1;
                    end
                end
                usbRxPkg::getPid: begin
                    if (stuffError || !lineValid) begin
                        dropFlag <= 1'b1;
                    end
                    if (eopSeen) begin
                        state <= usbRxPkg::rearm;
                    end else if (byteFull) begin
                        pidReg <= shiftReg[3:0];
                        if (!pidOk) begin
                            dropFlag <= 1'b1;
                        end
                        state <= usbRxPkg::waitEop;
                    end
                end
                usbRxPkg::waitEop: begin
                    if (stuffError) begin
                        dropFlag <= 1'b1;
                    end
                    if (eopSeen) begin
                        // Final CRC verdict
                        if (!lastCrcGood) begin
                            dropFlag <= 1'b1;
                        end
                        state <= usbRxPkg::rearm;
                    end else if (byteFull) begin
                        lastCrcGood <= crcGood;
                    end
                end
                default: begin
                    // Three flush clocks empty the pipeline
                    if (flushCnt == 2'd2) begin
                        flushCnt <= '0;
                        state <= usbRxPkg::waitSync;
                    end else begin
                        flushCnt <= flushCnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // ======================================
    // Tagging delay pipeline
    // ======================================
    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            pipe0 <= '0;
            pipe1 <= '0;
            pipe2 <= '0;
            pipeValid <= '0;
            dataTag <= '0;
            lastTag <= '0;
            byteOut <= '0;
            byteStrobe <= 1'b0;
            byteIsData <= 1'b0;
            byteIsLast <= 1'b0;
        end else begin
            byteStrobe <= 1'b0;
            if (shiftPipe || flushing) begin
                // Oldest byte leaves, newest enters
                byteOut <= pipe2;
                byteStrobe <= pipeValid[2];
                byteIsData <= dataTag[2];
                byteIsLast <= lastTag[2];
                pipe2 <= pipe1;
                pipe1 <= pipe0;
                pipe0 <= shiftReg;
                pipeValid <= {pipeValid[1:0], shiftPipe};
                dataTag <= {dataTag[1:0], shiftPipe};
                lastTag <= {lastTag[1:0], 1'b0};
            end else if (state == usbRxPkg::waitEop && eopSeen) begin
                if (isDataPid) begin
                    // Two newest bytes are the CRC16 field
                    dataTag[1:0] <= 2'b00;
                    lastTag <= 3'b100;
                end else begin
                    lastTag <= 3'b001;
                end
            end
        end
    end

endmodule

//--- hw/usbRxBytePort.sv
`timescale 1ns/10ps

module usbRxBytePort (
    input  logic clk48,
    input  logic rstN,
    input  logic byteStrobe,
    input  logic byteIsData,
    input  logic byteIsLast,
    input  logic packetDropped,
    input  logic rxAcceptNewData,
    input  usbRxPkg::UsbByte byteOut,
    output usbRxPkg::UsbByte rxData,
    output logic rxDataValid,
    output logic rxIsLastByte,
    output logic keepPacket
);

    logic overrunError;
    logic inPacket;
    logic newByte;

    assign newByte = byteStrobe & byteIsData;

    // ======================================
    // Valid/accept handshake
    // ======================================
    always_ff @(posedge clk48 or negedge rstN) begin
        if (!rstN) begin
            rxDataValid <= 1'b0;
            rxIsLastByte <= 1'b0;
            overrunError <= 1'b0;
            inPacket <= 1'b0;
        end else begin
            if (newByte) begin
                rxDataValid <= 1'b1;
                rxIsLastByte <= byteIsLast;
                // First byte of a packet starts clean
                // Unread byte being replaced marks an overrun
                overrunError <= (inPacket & overrunError) | (rxDataValid & ~rxAcceptNewData);
            end else if (rxDataValid && rxAcceptNewData) begin
                rxDataValid <= 1'b0;
            end
            // Packet boundary from the last tag of a data byte
            if (newByte) begin
                inPacket <= ~byteIsLast;
            end
        end
    end

    // Presented byte
    always_ff @(posedge clk48) begin
        if (newByte) begin
            rxData <= byteOut;
        end
    end

    assign keepPacket = ~(packetDropped | overrunError);

endmodule

//--- hw/usbRx.sv
`timescale 1ns/10ps

module usbRx #(
    parameter int resetSe0Clocks = 120,
    parameter int syncStages = 2
) (
    input  logic clk48,
    input  logic rstN,
    input  logic dataInP,
    input  logic dataInN,
    input  logic ackUsbReset,
    input  logic rxAcceptNewData,
    output logic usbResetDetect,
    output logic rxDataValid,
    output logic rxIsLastByte,
    output logic keepPacket,
    output usbRxPkg::UsbByte rxData
);

    // Line side
    logic bitStrobe;
    logic lineBit;
    logic lineValid;
    logic eopSeen;
    // Decoded bit stream
    logic decodedBit;
    logic bitValid;
    logic stuffError;
    logic rearm;
    // CRC control
    logic crcClear;
    logic useCrc16;
    logic crcGood;
    // Tagged bytes toward the byte port
    usbRxPkg::UsbByte byteOut;
    logic byteStrobe;
    logic byteIsData;
    logic byteIsLast;
    logic packetDropped;

    // ======================================
    // Input side
    // ======================================
    usbLineSampler #(
        .resetSe0Clocks(resetSe0Clocks),
        .syncStages(syncStages)
    ) lineSampler (
        .clk48(clk48),
        .rstN(rstN),
        .dataInP(dataInP),
        .dataInN(dataInN),
        .ackUsbReset(ackUsbReset),
        .bitStrobe(bitStrobe),
        .lineBit(lineBit),
        .lineValid(lineValid),
        .eopSeen(eopSeen),
        .usbResetDetect(usbResetDetect)
    );

    // ======================================
    // Bit and packet processing
    // ======================================
    usbBitDecoder bitDecoder (
        .clk48(clk48),
        .rstN(rstN),
        .bitStrobe(bitStrobe),
        .lineBit(lineBit),
        .rearm(rearm),
        .decodedBit(decodedBit),
        .bitValid(bitValid),
        .stuffError(stuffError)
    );

    usbRxCrc crcChecker (
        .clk48(clk48),
        .rstN(rstN),
        .crcClear(crcClear),
        .useCrc16(useCrc16),
        .bitValid(bitValid),
        .decodedBit(decodedBit),
        .crcGood(crcGood)
    );

    usbRxFramer framer (
        .clk48(clk48),
        .rstN(rstN),
        .decodedBit(decodedBit),
        .bitValid(bitValid),
        .stuffError(stuffError),
        .lineValid(lineValid),
        .eopSeen(eopSeen),
        .crcGood(crcGood),
        .crcClear(crcClear),
        .useCrc16(useCrc16),
        .rearm(rearm),
        .byteStrobe(byteStrobe),
        .byteIsData(byteIsData),
        .byteIsLast(byteIsLast),
        .packetDropped(packetDropped),
        .byteOut(byteOut)
    );

    // ======================================
    // Output side
    // ======================================
    usbRxBytePort bytePort (
        .clk48(clk48),
        .rstN(rstN),
        .byteStrobe(byteStrobe),
        .byteIsData(byteIsData),
        .byteIsLast(byteIsLast),
        .packetDropped(packetDropped),
        .rxAcceptNewData(rxAcceptNewData),
        .byteOut(byteOut),
        .rxData(rxData),
        .rxDataValid(rxDataValid),
        .rxIsLastByte(rxIsLastByte),
        .keepPacket(keepPacket)
    );

endmodule

//--- verification/usbRxChecker.sv
`timescale 1ns/10ps

module usbRxChecker (
    input logic clk48,
    input logic rstN,
    input usbRxPkg::UsbByte rxData,
    input logic rxDataValid,
    input logic rxAcceptNewData,
    input logic rxIsLastByte,
    input logic keepPacket,
    input logic usbResetDetect
);

    int errorCount;
    int gotCount;
    // 0 exact bytes, 1 corrupted packet, 2 slow reader
    int checkMode;
    logic active;
    logic packetDone;
    logic keepExpected;
    logic [191:0] testName;
    usbRxPkg::UsbByte expected[$];

    initial begin
        errorCount = 0;
        gotCount = 0;
        checkMode = 0;
        active = 1'b0;
        packetDone = 1'b0;
        keepExpected = 1'b1;
    end

    // ======================================
    // Expectations from the testbench
    // ======================================
    task automatic startPacket(input logic [191:0] name, input int mode, input logic keep);
        testName = name;
        checkMode = mode;
        keepExpected = keep;
        expected.delete();
        gotCount = 0;
        packetDone = 1'b0;
        active = 1'b1;
    endtask

    task automatic expectByte(input usbRxPkg::UsbByte value);
        expected.push_back(value);
    endtask

    task automatic checkResetFlag(input logic [191:0] name, input logic value);
        if (usbResetDetect !== value) begin
            errorCount++;
            $display("mismatch %0s usbResetDetect expected %0b actual %0b",
                     name, value, usbResetDetect);
        end
    endtask

    // ======================================
    // Byte consumption
    // ======================================
    task automatic consumeByte();
        int lastIndex;
        lastIndex = expected.size() - 1;
        if (!active) begin
            errorCount++;
            $display("Byte %h was delivered while no packet was being sent", rxData);
        end else begin
            if (checkMode == 0) begin
                if (gotCount > lastIndex) begin
                    errorCount++;
                    $display("Test %0s delivered more bytes than expected", testName);
                end else begin
                    if (rxData !== expected[gotCount]) begin
                        errorCount++;
                        $display("mismatch %0s byte %0d expected %h actual %h",
                                 testName, gotCount, expected[gotCount], rxData);
                    end
                    if (rxIsLastByte !== (gotCount == lastIndex)) begin
                        errorCount++;
                        $display("mismatch %0s last flag of byte %0d expected %0b actual %0b",
                                 testName, gotCount, gotCount == lastIndex, rxIsLastByte);
                    end
                end
            end
            gotCount++;
            if (rxIsLastByte) begin
                if (keepPacket !== keepExpected) begin
                    errorCount++;
                    $display("mismatch %0s keepPacket expected %0b actual %0b",
                             testName, keepExpected, keepPacket);
                end
                // Slow reader still ends on the real last byte
                if (checkMode == 2) begin
                    if (rxData !== expected[lastIndex]) begin
                        errorCount++;
                        $display("mismatch %0s last byte expected %h actual %h",
                                 testName, expected[lastIndex], rxData);
                    end
                    if (gotCount > lastIndex) begin
                        errorCount++;
                        $display("Test %0s lost no byte although the reader was slow",
                                 testName);
                    end
                end
                active = 1'b0;
                packetDone = 1'b1;
            end
        end
    endtask

    // Sampled before the DUT updates on this edge
    always @(posedge clk48) begin
        if (rstN && rxDataValid && rxAcceptNewData) begin
            consumeByte();
        end
    end

endmodule

//--- verification/usbRxTb.sv
`timescale 1ns/10ps

module usbRxTb;

    localparam int maxTests = 32;
    localparam int maxBytes = 512;
    localparam int idleBits = 16;

    logic clk48;
    logic rstN;
    logic dataInP;
    logic dataInN;
    logic ackUsbReset;
    logic rxAcceptNewData;
    logic usbResetDetect;
    logic rxDataValid;
    logic rxIsLastByte;
    logic keepPacket;
    usbRxPkg::UsbByte rxData;

    // Test table from the data file
    logic [191:0] testName [0:maxTests-1];
    logic [47:0] corruptCode [0:maxTests-1];
    logic isReset [0:maxTests-1];
    logic keepExpected [0:maxTests-1];
    int firstByte [0:maxTests-1];
    int byteCount [0:maxTests-1];
    int readerDelay [0:maxTests-1];
    int se0Bits [0:maxTests-1];
    usbRxPkg::UsbByte testBytes [0:maxBytes-1];
    int numTests;
    int testsRun;
    int fileErrors;
    int timeoutLimit;
    int cycleCount;
    int readerWait;
    int activeDelay;
    // Encoder state
    logic lineLevel;
    int onesRun;

    initial begin
        clk48 = 1'b0;
    end

    always #50 clk48 = ~clk48;

    usbRx #(
        .resetSe0Clocks(120),
        .syncStages(2)
    ) DUT (
        .clk48(clk48),
        .rstN(rstN),
        .dataInP(dataInP),
        .dataInN(dataInN),
        .ackUsbReset(ackUsbReset),
        .rxAcceptNewData(rxAcceptNewData),
        .usbResetDetect(usbResetDetect),
        .rxDataValid(rxDataValid),
        .rxIsLastByte(rxIsLastByte),
        .keepPacket(keepPacket),
        .rxData(rxData)
    );

    usbRxChecker rxCheck (
        .clk48(clk48),
        .rstN(rstN),
        .rxData(rxData),
        .rxDataValid(rxDataValid),
        .rxAcceptNewData(rxAcceptNewData),
        .rxIsLastByte(rxIsLastByte),
        .keepPacket(keepPacket),
        .usbResetDetect(usbResetDetect)
    );

    // ========================================
    // Test file reader
    // ========================================
    task automatic loadTests();
        int fd;
        int code;
        int count;
        int value;
        int keepInt;
        int nextByte;
        logic [191:0] word;
        logic [8*160-1:0] restLine;
        numTests = 0;
        nextByte = 0;
        fd = $fopen("verification/usbRxTests.txt", "r");
        if (fd == 0) begin
            fileErrors++;
            $display("Could not open verification/usbRxTests.txt");
        end else begin
            while (!$feof(fd) && numTests < maxTests) begin
                code = $fscanf(fd, "%s", word);
                if (code != 1) begin
                    code = $fgets(restLine, fd);
                end else if (word == "#") begin
                    code = $fgets(restLine, fd);
                end else if (word == "rst") begin
                    code = $fscanf(fd, "%s %d", testName[numTests], se0Bits[numTests]);
                    isReset[numTests] = 1'b1;
                    numTests++;
                end else if (word == "pkt") begin
                    code = $fscanf(fd, "%s %d", testName[numTests], count);
                    firstByte[numTests] = nextByte;
                    byteCount[numTests] = count;
                    for (int i = 0; i < count; i++) begin
                        code = $fscanf(fd, "%h", value);
                        testBytes[nextByte] = value[7:0];
                        nextByte++;
                    end
                    code = $fscanf(fd, "%s %d %d", corruptCode[numTests],
                                   readerDelay[numTests], keepInt);
                    keepExpected[numTests] = keepInt[0];
                    isReset[numTests] = 1'b0;
                    numTests++;
                end else begin
                    fileErrors++;
                    $display("Unknown line kind %0s in the test file", word);
                    code = $fgets(restLine, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    // SYNC, payload with worst-case stuffing, raw ones and EOP
    function automatic int packetBits(input int count);
        return 8 + 8 * count + (8 * (count + 1)) / 6 + 7 + 3;
    endfunction

    // ========================================
    // Line encoder
    // ========================================
    task automatic driveState(input logic p, input logic n);
        @(posedge clk48);
        #1;
        dataInP = p;
        dataInN = n;
        repeat (usbRxPkg::clksPerBit - 1) @(posedge clk48);
    endtask

    // NRZI with a zero stuffed after six ones
    task automatic sendBit(input logic b);
        if (!b) begin
            lineLevel = ~lineLevel;
        end
        driveState(lineLevel, ~lineLevel);
        onesRun = b ? onesRun + 1 : 0;
        if (onesRun == 6) begin
            lineLevel = ~lineLevel;
            driveState(lineLevel, ~lineLevel);
            onesRun = 0;
        end
    endtask

    task automatic sendByte(input usbRxPkg::UsbByte value);
        for (int i = 0; i < 8; i++) begin
            sendBit(value[i]);
        end
    endtask

    // Unstuffed ones break the stuffing rule
    task automatic sendRawOnes(input int count);
        repeat (count) driveState(lineLevel, ~lineLevel);
        onesRun = 0;
    endtask

    task automatic sendIdle(input int bits);
        lineLevel = 1'b1;
        repeat (bits) driveState(1'b1, 1'b0);
    endtask

    task automatic sendEop();
        driveState(1'b0, 1'b0);
        driveState(1'b0, 1'b0);
        sendIdle(1);
    endtask

    // ========================================
    // Test runners
    // ========================================
    task automatic runPacket(input int t);
        int n;
        int keepCount;
        int mode;
        logic isData;
        usbRxPkg::UsbByte value;
        n = byteCount[t];
        // Data PIDs withhold their two CRC bytes
        isData = (testBytes[firstByte[t]][1:0] == 2'b11);
        keepCount = isData ? n - 2 : n;
        if (corruptCode[t] != "none") begin
            mode = 1;
        end else if (!keepExpected[t]) begin
            mode = 2;
        end else begin
            mode = 0;
        end
        rxCheck.startPacket(testName[t], mode, keepExpected[t]);
        for (int i = 0; i < keepCount; i++) begin
            rxCheck.expectByte(testBytes[firstByte[t] + i]);
        end
        activeDelay = readerDelay[t];
        onesRun = 0;
        sendByte(8'h80);
        for (int i = 0; i < n; i++) begin
            value = testBytes[firstByte[t] + i];
            if (i == 0 && corruptCode[t] == "pid") begin
                value[7] = ~value[7];
            end
            if (i == n - 1 && corruptCode[t] == "crc") begin
                value[0] = ~value[0];
            end
            sendByte(value);
            if (i == 0 && corruptCode[t] == "stuff") begin
                sendRawOnes(7);
            end
        end
        sendEop();
        // Last byte reaches the checker after the reader takes it
        while (!rxCheck.packetDone) @(posedge clk48);
        sendIdle(idleBits);
    endtask

    task automatic runReset(input int t);
        rxCheck.checkResetFlag(testName[t], 1'b0);
        repeat (se0Bits[t]) driveState(1'b0, 1'b0);
        sendIdle(1);
        rxCheck.checkResetFlag(testName[t], 1'b1);
        // Flag holds until acknowledged
        sendIdle(4);
        rxCheck.checkResetFlag(testName[t], 1'b1);
        @(posedge clk48);
        #1;
        ackUsbReset = 1'b1;
        @(posedge clk48);
        #1;
        ackUsbReset = 1'b0;
        rxCheck.checkResetFlag(testName[t], 1'b0);
        sendIdle(idleBits);
    endtask

    // ========================================
    // Reader emulation and timeout
    // ========================================
    always @(posedge clk48) begin
        #1;
        rxAcceptNewData = 1'b0;
        if (rxDataValid) begin
            if (readerWait >= activeDelay) begin
                rxAcceptNewData = 1'b1;
                readerWait = 0;
            end else begin
                readerWait++;
            end
        end else begin
            readerWait = 0;
        end
    end

    always @(posedge clk48) begin
        cycleCount++;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
            $display("Timeout after %0d cycles while running test %0d", cycleCount, testsRun);
            $display("Tests run: %0d, errors: %0d", testsRun,
                     rxCheck.errorCount + fileErrors + 1);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int totalBits;
        rstN = 1'b0;
        dataInP = 1'b1;
        dataInN = 1'b0;
        ackUsbReset = 1'b0;
        rxAcceptNewData = 1'b0;
        readerWait = 0;
        activeDelay = 0;
        lineLevel = 1'b1;
        onesRun = 0;
        cycleCount = 0;
        timeoutLimit = 0;
        testsRun = 0;
        fileErrors = 0;
        loadTests();
        totalBits = idleBits;
        for (int t = 0; t < numTests; t++) begin
            if (isReset[t]) begin
                totalBits += se0Bits[t] + idleBits + 8;
            end else begin
                totalBits += packetBits(byteCount[t]) + idleBits;
            end
        end
        timeoutLimit = totalBits * usbRxPkg::clksPerBit + 2000;
        repeat (10) @(posedge clk48);
        #1;
        rstN = 1'b1;
        sendIdle(idleBits);
        for (int t = 0; t < numTests; t++) begin
            if (isReset[t]) begin
                runReset(t);
            end else begin
                runPacket(t);
            end
            testsRun++;
        end
        if (numTests == 0) begin
            fileErrors++;
            $display("No tests were read from the test file");
        end
        $display("Tests run: %0d, errors: %0d", testsRun, rxCheck.errorCount + fileErrors);
        if (rxCheck.errorCount + fileErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- verification/usbRxTests.txt
# pkt name byteCount bytes(hex, PID first, CRC included) corrupt(none|crc|pid|stuff) readerDelay keep
# rst name se0LengthInBitTimes
pkt data0OneByte 4 c3 00 40 bf none 2 1
pkt data1TwoBytes 5 4b 00 a5 3e 34 none 3 1
pkt setupToken 3 2d 00 10 none 0 1
pkt inToken 3 69 00 10 none 0 1
pkt data0BadCrc 4 c3 00 40 bf crc 2 0
pkt tokenBadCrc 3 2d 00 10 crc 0 0
pkt data1BadPid 5 4b 00 a5 3e 34 pid 2 0
pkt data0StuffErr 4 c3 00 40 bf stuff 2 0
pkt recoverGood 4 c3 00 40 bf none 0 1
pkt slowReader 5 4b 00 a5 3e 34 none 40 0
pkt afterOverrun 3 69 00 10 none 0 1
rst busReset 40
pkt afterReset 5 4b 00 a5 3e 34 none 1 1

//--- all.f
hw/usbRxPkg.sv
hw/usbLineSampler.sv
hw/usbBitDecoder.sv
hw/usbRxCrc.sv
hw/usbRxFramer.sv
hw/usbRxBytePort.sv
hw/usbRx.sv
verification/usbRxChecker.sv
verification/usbRxTb.sv
